// File: ack_builder.sv
/*
  Acknowledge builder
  Sums payload bytes and emits a three-word record per packet
*/
`timescale 1ns/1ps

module ack_builder (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  pkt_comm_pkg::payload_t pay,
  input  logic                   pay_valid,
  output logic                   pay_ready,
  output logic [15:0]            word,
  output logic                   word_valid,
  output logic                   word_last,
  input  logic                   word_accept
);

  logic [15:0] sum;
  logic [15:0] sum_next;
  logic        take;

  // Held record
  logic        rec_valid;
  logic [1:0]  idx;
  logic [7:0]  rec_type;
  logic [15:0] rec_id;
  logic [15:0] rec_sum;

  // Only the closing beat has to wait for a free record slot
  assign pay_ready = ~(pay.last & rec_valid);
  assign take      = pay_valid & pay_ready;
  assign sum_next  = sum + {8'd0, pay.data};

  always_comb begin
    case (idx)
      2'd0:    word = {rec_type, pkt_comm_pkg::ACK_TYPE};
      2'd1:    word = rec_id;
      default: word = rec_sum;
    endcase
  end

  assign word_valid = rec_valid;
  assign word_last  = (idx == 2'd2);

  always_ff @(posedge CLK) begin
    if (take && pay.last) begin
      rec_type <= pay.ptype;
      rec_id   <= pay.id;
      rec_sum  <= {pay.len_err, sum_next[14:0]};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      sum       <= '0;
      rec_valid <= 1'b0;
      idx       <= '0;
    end else begin
      if (take) begin
        sum <= pay.last ? 16'd0 : sum_next;
      end
      if (take && pay.last) begin
        rec_valid <= 1'b1;
        idx       <= '0;
      end else if (word_accept) begin
        if (word_last) begin
          rec_valid <= 1'b0;
          idx       <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

endmodule

// File: axis_byte_fifo.sv
/*
  Input byte FIFO
  Buffers stream bytes with tlast and drives ready from free space
*/
`timescale 1ns/1ps

module axis_byte_fifo (
  input  logic                     CLK,
  input  logic                     RSTN,
  input  logic [7:0]               s_tdata,
  input  logic                     s_tvalid,
  input  logic                     s_tlast,
  output logic                     s_tready,
  output pkt_comm_pkg::byte_beat_t beat,
  output logic                     beat_valid,
  input  logic                     pop
);

  pkt_comm_pkg::byte_beat_t         mem [pkt_comm_pkg::FIFO_DEPTH];
  logic [pkt_comm_pkg::FIFO_AW:0]   wr_ptr;
  logic [pkt_comm_pkg::FIFO_AW:0]   rd_ptr;
  logic                             full;

  // Wrap bits differ and index bits match when full
  assign full = (wr_ptr[pkt_comm_pkg::FIFO_AW] != rd_ptr[pkt_comm_pkg::FIFO_AW]) &&
                (wr_ptr[pkt_comm_pkg::FIFO_AW-1:0] == rd_ptr[pkt_comm_pkg::FIFO_AW-1:0]);

  assign s_tready   = ~full;
  assign beat_valid = (wr_ptr != rd_ptr);
  assign beat       = mem[rd_ptr[pkt_comm_pkg::FIFO_AW-1:0]];

  always_ff @(posedge CLK) begin
    if (s_tvalid && s_tready) begin
      mem[wr_ptr[pkt_comm_pkg::FIFO_AW-1:0]] <= '{data: s_tdata, last: s_tlast};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (s_tvalid && s_tready) wr_ptr <= wr_ptr + 1'b1;
      if (pop && beat_valid)    rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// File: compile.f
pkt_comm_pkg.sv
axis_byte_fifo.sv
pkt_header_parser.sv
ack_builder.sv
word_to_byte_tx.sv
pkt_comm_top.sv
pkt_comm_checker.sv
tb_pkt_comm.sv

// File: pkt_comm_checker.sv
/*
  Packet front end checker
  Assertions on the output stream hold rule, reset state and sticky error
*/
`timescale 1ns/1ps

module pkt_comm_checker (
  input logic       CLK,
  input logic       RSTN,
  input logic [7:0] m_axis_tdata,
  input logic       m_axis_tvalid,
  input logic       m_axis_tready,
  input logic       m_axis_tlast,
  input logic       error,
  input logic       idle
);

  int fail_count = 0;

  // A stalled byte stays put until the sink takes it
  a_hold_stable: assert property (@(posedge CLK) disable iff (!RSTN)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
  else begin
    $error("output byte or tlast changed while the sink stalled");
    fail_count++;
  end

  // Quiet outputs in the first cycle after reset release
  a_reset_state: assert property (@(posedge CLK)
    $rose(RSTN) |-> !m_axis_tvalid && !m_axis_tlast && idle && !error)
  else begin
    $error("outputs not in their reset state after reset");
    fail_count++;
  end

  // Only reset may clear error
  a_error_sticky: assert property (@(posedge CLK) disable iff (!RSTN) error |=> error)
  else begin
    $error("error output fell without a reset");
    fail_count++;
  end

endmodule

// File: pkt_comm_pkg.sv
/*
  Packet communication package
  Header layout constants, packet types and the structs passed between stages
*/
package pkt_comm_pkg;

  // Header format
  localparam logic [7:0] PKT_VERSION = 8'd2;
  localparam int         HDR_LEN     = 10;
  localparam int         PKT_MAX_LEN = 16 * 65536;

  // Input buffering
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // Acknowledge record type byte
  localparam logic [7:0] ACK_TYPE = 8'h81;

  typedef enum logic [7:0] {
    WORD_LIST     = 8'd1,
    WORD_GEN      = 8'd2,
    CMP_CONFIG    = 8'd3,
    TEMPLATE_LIST = 8'd4
  } pkt_type_e;

  // One input byte with its tlast
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  // Payload byte with its packet context
  typedef struct packed {
    logic [7:0]  data;
    logic        last;
    logic [7:0]  ptype;
    logic [15:0] id;
    logic        len_err;
  } payload_t;

  typedef struct packed {
    logic ver_err;
    logic type_err;
    logic len_err;
    logic overflow;
  } status_t;

endpackage

// File: pkt_comm_top.sv
/*
  Packet communication front end
  FIFO, header parser, acknowledge builder and serializer in one pipeline
*/
`timescale 1ns/1ps

module pkt_comm_top (
  input  logic                  CLK,
  input  logic                  RSTN,
  input  logic [7:0]            s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  output logic [7:0]            m_axis_tdata,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast,
  output pkt_comm_pkg::status_t pkt_status,
  output logic                  error,
  output logic                  idle
);

  pkt_comm_pkg::byte_beat_t beat;
  logic                     beat_valid;
  logic                     pop;
  pkt_comm_pkg::payload_t   pay;
  logic                     pay_valid;
  logic                     pay_ready;
  logic                     busy;
  logic [15:0]              word;
  logic                     word_valid;
  logic                     word_last;
  logic                     word_accept;

  axis_byte_fifo fifo_inst (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .s_tdata    (s_axis_tdata),
    .s_tvalid   (s_axis_tvalid),
    .s_tlast    (s_axis_tlast),
    .s_tready   (s_axis_tready),
    .beat       (beat),
    .beat_valid (beat_valid),
    .pop        (pop)
  );

  pkt_header_parser parser_inst (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .beat       (beat),
    .beat_valid (beat_valid),
    .pop        (pop),
    .pay        (pay),
    .pay_valid  (pay_valid),
    .pay_ready  (pay_ready),
    .status     (pkt_status),
    .busy       (busy)
  );

  ack_builder ack_inst (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .pay         (pay),
    .pay_valid   (pay_valid),
    .pay_ready   (pay_ready),
    .word        (word),
    .word_valid  (word_valid),
    .word_last   (word_last),
    .word_accept (word_accept)
  );

  word_to_byte_tx tx_inst (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .word        (word),
    .word_valid  (word_valid),
    .word_last   (word_last),
    .word_accept (word_accept),
    .m_tdata     (m_axis_tdata),
    .m_tvalid    (m_axis_tvalid),
    .m_tready    (m_axis_tready),
    .m_tlast     (m_axis_tlast)
  );

  // Sticky error cleared by reset only
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      error <= 1'b0;
    end else if (|pkt_status) begin
      error <= 1'b1;
    end
  end

  // Nothing arriving, buffered or in flight
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      idle <= 1'b1;
    end else begin
      idle <= ~s_axis_tvalid & ~beat_valid & ~busy & ~word_valid & ~m_axis_tvalid;
    end
  end

endmodule

// File: pkt_header_parser.sv
/*
  Packet header parser
  Checks the 10-byte header, frames the payload and discards bad packets
*/
`timescale 1ns/1ps

module pkt_header_parser (
  input  logic                     CLK,
  input  logic                     RSTN,
  input  pkt_comm_pkg::byte_beat_t beat,
  input  logic                     beat_valid,
  output logic                     pop,
  output pkt_comm_pkg::payload_t   pay,
  output logic                     pay_valid,
  input  logic                     pay_ready,
  output pkt_comm_pkg::status_t    status,
  output logic                     busy
);

  typedef enum logic [1:0] {
    HEADER,
    PAYLOAD,
    DISCARD
  } state_e;

  state_e      state;
  logic [3:0]  hdr_cnt;
  logic [23:0] remaining;

  // Header fields
  logic [7:0]  ver;
  logic [7:0]  ptype;
  logic [23:0] len;
  logic [15:0] id;

  logic        hdr_done;
  logic        ver_ok;
  logic        type_ok;
  logic        len_ok;
  logic        rem_one;

  assign hdr_done = (hdr_cnt == 4'(pkt_comm_pkg::HDR_LEN - 1));
  assign ver_ok   = (ver == pkt_comm_pkg::PKT_VERSION);
  assign type_ok  = (ptype == pkt_comm_pkg::WORD_LIST) || (ptype == pkt_comm_pkg::WORD_GEN) ||
                    (ptype == pkt_comm_pkg::CMP_CONFIG) || (ptype == pkt_comm_pkg::TEMPLATE_LIST);
  assign len_ok   = (len != 24'd0) && (len <= pkt_comm_pkg::PKT_MAX_LEN);
  assign rem_one  = (remaining == 24'd1);

  // Header and discard bytes never wait on the builder
  assign pop       = beat_valid && ((state != PAYLOAD) || pay_ready);
  assign pay_valid = beat_valid && (state == PAYLOAD);

  // Payload-last on tlast or on count end and flagged when they disagree
  assign pay.data    = beat.data;
  assign pay.last    = beat.last | rem_one;
  assign pay.ptype   = ptype;
  assign pay.id      = id;
  assign pay.len_err = beat.last ^ rem_one;

  assign busy = (state != HEADER) || (hdr_cnt != 4'd0);

  always_ff @(posedge CLK) begin
    if (pop && state == HEADER) begin
      case (hdr_cnt)
        4'd0: ver        <= beat.data;
        4'd1: ptype      <= beat.data;
        4'd4: len[7:0]   <= beat.data;
        4'd5: len[15:8]  <= beat.data;
        4'd6: len[23:16] <= beat.data;
        4'd8: id[7:0]    <= beat.data;
        4'd9: id[15:8]   <= beat.data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state     <= HEADER;
      hdr_cnt   <= '0;
      remaining <= '0;
      status    <= '0;
    end else if (pop) begin
      case (state)
        HEADER: begin
          if (beat.last) begin
            // Header cut short
            status.len_err <= 1'b1;
            hdr_cnt        <= '0;
          end else if (hdr_done) begin
            hdr_cnt <= '0;
            if (ver_ok && type_ok && len_ok) begin
              state     <= PAYLOAD;
              remaining <= len;
            end else begin
              state <= DISCARD;
              if (!ver_ok)  status.ver_err  <= 1'b1;
              if (!type_ok) status.type_err <= 1'b1;
              if (!len_ok)  status.len_err  <= 1'b1;
            end
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
          end
        end
        PAYLOAD: begin
          remaining <= remaining - 1'b1;
          if (beat.last) begin
            state <= HEADER;
            if (!rem_one) status.len_err <= 1'b1;
          end else if (rem_one) begin
            // Packet runs past its declared length
            state           <= DISCARD;
            status.overflow <= 1'b1;
          end
        end
        DISCARD: begin
          if (beat.last) state <= HEADER;
        end
        default: state <= HEADER;
      endcase
    end
  end

endmodule

// File: tb_pkt_comm.sv
/*
  Testbench for the packet front end
  Directed packets in, acknowledge bytes checked against the header and payload
*/
`timescale 1ns/1ps

module tb_pkt_comm;

  // Worst-case bytes sent over all tests and the longest m_tready gap
  localparam int MAX_BYTES      = 320;
  localparam int GAP_MAX        = 47;
  localparam int TIMEOUT_CYCLES = MAX_BYTES * 4 + 18 * (GAP_MAX + 1) + 500;

  logic                  CLK;
  logic                  RSTN;
  logic [7:0]            s_axis_tdata;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic                  s_axis_tlast;
  logic [7:0]            m_axis_tdata;
  logic                  m_axis_tvalid;
  logic                  m_axis_tready;
  logic                  m_axis_tlast;
  pkt_comm_pkg::status_t pkt_status;
  logic                  error;
  logic                  idle;

  logic [31:0] lfsr_state = 32'h6ea31558;
  logic [7:0]  pay_buf [0:255];
  logic [8:0]  rx_q [$];
  logic [8:0]  exp_q [$];
  logic        bp_on = 1'b0;
  logic        saw_stall = 1'b0;
  int          gap_cnt = 0;
  int          cycle_cnt = 0;
  int          n_checks = 0;
  int          n_errors = 0;

  pkt_comm_top pkt_comm_top_inst (.*);

  bind pkt_comm_top pkt_comm_checker checker_inst (
    .CLK           (CLK),
    .RSTN          (RSTN),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .error         (error),
    .idle          (idle)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h80200003;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) val = {val[30:0], next_rand_bit()};
    return val;
  endfunction

  function automatic logic [15:0] payload_sum(input int off, input int n);
    logic [15:0] sum;
    sum = '0;
    for (int i = 0; i < n; i++) sum = sum + pay_buf[off + i];
    return sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int start);
    $display("test %s: %0d errors", name, n_errors - start);
  endtask

  task automatic fill_payload(input int off, input int n);
    for (int i = 0; i < n; i++) pay_buf[off + i] = 8'(rand_bits(8));
  endtask

  // Record bytes are type code, packet type, id, then sum with bit 15 as the length flag
  task automatic expect_ack(input logic [7:0] ptype, input logic [15:0] id,
                            input logic [15:0] sum, input logic len_err);
    logic [15:0] w2;
    w2 = {len_err, sum[14:0]};
    exp_q.push_back({1'b0, pkt_comm_pkg::ACK_TYPE});
    exp_q.push_back({1'b0, ptype});
    exp_q.push_back({1'b0, id[7:0]});
    exp_q.push_back({1'b0, id[15:8]});
    exp_q.push_back({1'b0, w2[7:0]});
    exp_q.push_back({1'b1, w2[15:8]});
  endtask

  task automatic send_byte(input logic [7:0] data, input logic last);
    s_axis_tdata  <= data;
    s_axis_tlast  <= last;
    s_axis_tvalid <= 1'b1;
    @(posedge CLK);
    while (!s_axis_tready) @(posedge CLK);
  endtask

  task automatic send_packet(input logic [7:0] ver, input logic [7:0] ptype,
                             input logic [23:0] len, input logic [15:0] id,
                             input int off, input int n);
    logic [7:0] hdr [0:9];
    hdr = '{ver, ptype, 8'h00, 8'h00, len[7:0], len[15:8], len[23:16], 8'h00,
            id[7:0], id[15:8]};
    for (int i = 0; i < 10; i++) send_byte(hdr[i], 1'b0);
    for (int i = 0; i < n; i++) send_byte(pay_buf[off + i], i == n - 1);
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic wait_idle();
    repeat (2) @(posedge CLK);
    while (!idle) @(posedge CLK);
  endtask

  task automatic compare_acks();
    check_value("ack byte count", rx_q.size(), exp_q.size());
    for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
      check_value($sformatf("m_axis_tdata[%0d]", i), rx_q[i][7:0], exp_q[i][7:0]);
      check_value($sformatf("m_axis_tlast[%0d]", i), rx_q[i][8], exp_q[i][8]);
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic test_reset();
    int start;
    start = n_errors;
    check_value("s_axis_tready", s_axis_tready, 1);
    check_value("m_axis_tvalid", m_axis_tvalid, 0);
    check_value("pkt_status", pkt_status, 0);
    check_value("error", error, 0);
    check_value("idle", idle, 1);
    finish_test("reset_state", start);
  endtask

  task automatic test_good_types();
    int          start;
    int          n;
    logic [15:0] id;
    start = n_errors;
    for (int t = 1; t <= 4; t++) begin
      n  = 1 + int'(rand_bits(5)) % 20;
      id = 16'(rand_bits(16));
      fill_payload(0, n);
      expect_ack(8'(t), id, payload_sum(0, n), 1'b0);
      send_packet(pkt_comm_pkg::PKT_VERSION, 8'(t), 24'(n), id, 0, n);
      wait_idle();
      compare_acks();
    end
    finish_test("good_types", start);
  endtask

  task automatic test_bad_header();
    int start;
    start = n_errors;
    fill_payload(0, 4);
    send_packet(8'd3, 8'd1, 24'd4, 16'h1234, 0, 4);
    wait_idle();
    compare_acks();
    check_value("pkt_status.ver_err", pkt_status.ver_err, 1);
    check_value("error", error, 1);
    send_packet(pkt_comm_pkg::PKT_VERSION, 8'd7, 24'd4, 16'h5678, 0, 4);
    wait_idle();
    compare_acks();
    check_value("pkt_status.type_err", pkt_status.type_err, 1);
    // Parser must have recovered for a normal packet
    expect_ack(8'd2, 16'h9abc, payload_sum(0, 4), 1'b0);
    send_packet(pkt_comm_pkg::PKT_VERSION, 8'd2, 24'd4, 16'h9abc, 0, 4);
    wait_idle();
    compare_acks();
    finish_test("bad_header", start);
  endtask

  task automatic test_short_packet();
    int          start;
    int          n;
    logic [15:0] id;
    start = n_errors;
    n  = 3 + int'(rand_bits(4)) % 18;
    id = 16'(rand_bits(16));
    fill_payload(0, n);
    expect_ack(8'd3, id, payload_sum(0, n), 1'b1);
    // Declared length runs two bytes past tlast
    send_packet(pkt_comm_pkg::PKT_VERSION, 8'd3, 24'(n + 2), id, 0, n);
    wait_idle();
    compare_acks();
    check_value("pkt_status.len_err", pkt_status.len_err, 1);
    finish_test("short_packet", start);
  endtask

  task automatic test_backpressure();
    int start;
    start = n_errors;
    saw_stall = 1'b0;
    // Long third packet fills the FIFO while the second waits for a record slot
    fill_payload(0, 3);
    fill_payload(3, 1);
    fill_payload(4, 80);
    expect_ack(8'd1, 16'h0a01, payload_sum(0, 3), 1'b0);
    expect_ack(8'd2, 16'h0a02, payload_sum(3, 1), 1'b0);
    expect_ack(8'd4, 16'h0a03, payload_sum(4, 80), 1'b0);
    bp_on <= 1'b1;
    send_packet(pkt_comm_pkg::PKT_VERSION, 8'd1, 24'd3, 16'h0a01, 0, 3);
    send_packet(pkt_comm_pkg::PKT_VERSION, 8'd2, 24'd1, 16'h0a02, 3, 1);
    send_packet(pkt_comm_pkg::PKT_VERSION, 8'd4, 24'd80, 16'h0a03, 4, 80);
    wait_idle();
    bp_on <= 1'b0;
    compare_acks();
    check_value("s_axis_tready low seen", saw_stall, 1);
    check_value("m_axis_tvalid", m_axis_tvalid, 0);
    finish_test("backpressure", start);
  endtask

  // Sink ready pulses between random gaps under back-pressure
  always @(posedge CLK) begin
    if (!bp_on) begin
      m_axis_tready <= 1'b1;
    end else if (gap_cnt > 0) begin
      m_axis_tready <= 1'b0;
      gap_cnt = gap_cnt - 1;
    end else begin
      m_axis_tready <= 1'b1;
      gap_cnt = 32 + int'(rand_bits(4));
    end
  end

  always @(posedge CLK) begin
    if (RSTN && m_axis_tvalid && m_axis_tready) rx_q.push_back({m_axis_tlast, m_axis_tdata});
    if (RSTN && !s_axis_tready) saw_stall = 1'b1;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    RSTN          = 1'b0;
    s_axis_tdata  = 8'h00;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    repeat (10) @(posedge CLK);
    RSTN <= 1'b1;
    @(posedge CLK);
    test_reset();
    test_good_types();
    test_bad_header();
    test_short_packet();
    test_backpressure();
    n_errors = n_errors + pkt_comm_top_inst.checker_inst.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
             pkt_comm_top_inst.checker_inst.fail_count);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: word_to_byte_tx.sv
/*
  Word to byte serializer
  Sends each 16-bit word low byte first on the output stream
*/
`timescale 1ns/1ps

module word_to_byte_tx (
  input  logic        CLK,
  input  logic        RSTN,
  input  logic [15:0] word,
  input  logic        word_valid,
  input  logic        word_last,
  output logic        word_accept,
  output logic [7:0]  m_tdata,
  output logic        m_tvalid,
  input  logic        m_tready,
  output logic        m_tlast
);

  typedef enum logic {
    LO,
    HI
  } state_e;

  state_e      state;
  logic [15:0] shreg;
  logic        last_reg;
  logic        vld;

  // Load only once both bytes of the previous word are gone
  assign word_accept = (state == LO) && !vld && word_valid;

  assign m_tdata  = (state == LO) ? shreg[7:0] : shreg[15:8];
  assign m_tvalid = vld;
  assign m_tlast  = vld && (state == HI) && last_reg;

  always_ff @(posedge CLK) begin
    if (word_accept) begin
      shreg    <= word;
      last_reg <= word_last;
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state <= LO;
      vld   <= 1'b0;
    end else begin
      case (state)
        LO: begin
          if (word_accept) vld <= 1'b1;
          if (vld && m_tready) state <= HI;
        end
        HI: begin
          if (vld && m_tready) begin
            vld   <= 1'b0;
            state <= LO;
          end
        end
        default: state <= LO;
      endcase
    end
  end

endmodule
